// File: hssl_interface.f
hssl_link_pkg.sv
hssl_pkt_pkg.sv
hssl_pkt_fifo.sv
hssl_frame_assembler.sv
hssl_frame_disassembler.sv
hssl_tx_control.sv
hssl_rx_control.sv
hssl_interface.sv
hssl_interface_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module hssl_interface_tb -f hssl_interface.f -o hssl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "compile failed"
  exit 1
fi

./obj_dir/hssl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

// File: hssl_interface_tb.sv
// ----------------------------------------------------------
// loopback testbench for the four-channel link multiplexer
//   link_tx wired back to link_rx, or injected words
//   per-channel expected queues filled from accepted tx packets
//   directed tests and typed compare tasks
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_interface_tb;

  import hssl_link_pkg::*;
  import hssl_pkt_pkg::*;

  logic              clk = 1'b0;
  logic              arst_n;
  logic [15:0]       link_id;
  logic              stop;
  pkt_t              tx_data [NUM_CH];
  logic [NUM_CH-1:0] tx_vld;
  logic [NUM_CH-1:0] tx_rdy;
  pkt_t              rx_data [NUM_CH];
  logic [NUM_CH-1:0] rx_vld;
  logic [NUM_CH-1:0] rx_rdy;
  logic              handshake_complete;
  logic              version_mismatch;
  logic [15:0]       peer_id;
  logic [31:0]       link_tx_data;
  logic [3:0]        link_tx_k;
  logic [31:0]       link_rx_data;
  logic [3:0]        link_rx_k;

  // injection switch replaces the returning link words
  logic              inject;
  logic [31:0]       inj_data;
  logic [3:0]        inj_k;

  // scoreboard
  pkt_t        exp_q [NUM_CH][$];
  int          quota [NUM_CH];
  int          sent  [NUM_CH];
  bit          quiet;
  int          err_cnt;
  int          chk_cnt;
  logic [31:0] lcg_state = 32'd93;

  // 20 ns clock
  always #10 clk = ~clk;

  assign link_rx_data = inject ? inj_data : link_tx_data;
  assign link_rx_k    = inject ? inj_k    : link_tx_k;

  hssl_interface dut_i (
      .clk                (clk)
    , .arst_n             (arst_n)
    , .link_id            (link_id)
    , .stop               (stop)
    , .tx_data            (tx_data)
    , .tx_vld             (tx_vld)
    , .tx_rdy             (tx_rdy)
    , .rx_data            (rx_data)
    , .rx_vld             (rx_vld)
    , .rx_rdy             (rx_rdy)
    , .handshake_complete (handshake_complete)
    , .version_mismatch   (version_mismatch)
    , .peer_id            (peer_id)
    , .link_tx_data       (link_tx_data)
    , .link_tx_k          (link_tx_k)
    , .link_rx_data       (link_rx_data)
    , .link_rx_k          (link_rx_k)
  );

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------
  task automatic compare_pkt(input pkt_t got, input pkt_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_ch(input ch_t got, input ch_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_id(input logic [15:0] got, input logic [15:0] exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_word(input link_word_t got, input link_word_t exp,
                              input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %h/%b expected %h/%b", $time, what,
               got.data, got.k, exp.data, exp.k);
    end
  endtask

  task automatic compare_credit(input credit_t got, input credit_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_mask(input logic [NUM_CH-1:0] got, input logic [NUM_CH-1:0] exp,
                              input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    err_cnt++;
    $display("timed out at %0t while waiting for %s", $time, what);
  endtask

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // channel number in the top bits, random below
  function automatic pkt_t make_pkt(input ch_t c);
    logic [31:0] r;
    r = lcg_next();
    return {c, r[PKT_BITS-$bits(ch_t)-1:0]};
  endfunction

  task automatic apply_reset();
    arst_n <= 1'b0;
    stop   <= 1'b0;
    tx_vld <= '0;
    rx_rdy <= '1;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic load_quota(input int q0, input int q1, input int q2, input int q3);
    quota[0] = q0;
    quota[1] = q1;
    quota[2] = q2;
    quota[3] = q3;
    for (int c = 0; c < NUM_CH; c++) begin
      sent[c] = 0;
    end
  endtask

  // offers packets until every channel has sent its quota or limit runs out
  task automatic stream(input int limit, output bit done);
    int n;
    n    = 0;
    done = 1'b0;
    while (!done && n < limit) begin
      @(posedge clk);
      n++;
      done = 1'b1;
      for (int c = 0; c < NUM_CH; c++) begin
        if (tx_vld[c] && tx_rdy[c]) begin
          sent[c]++;
        end
        // data held until accepted
        if (!tx_vld[c] || tx_rdy[c]) begin
          if (sent[c] < quota[c]) begin
            tx_data[c] <= make_pkt(ch_t'(c));
            tx_vld[c]  <= 1'b1;
          end else begin
            tx_vld[c] <= 1'b0;
          end
        end
        if (sent[c] < quota[c]) begin
          done = 1'b0;
        end
      end
    end
  endtask

  task automatic wait_drain(input logic [NUM_CH-1:0] mask, input int limit);
    int n;
    bit busy;
    n    = 0;
    busy = 1'b1;
    while (busy && n < limit) begin
      @(posedge clk);
      n++;
      busy = 1'b0;
      for (int c = 0; c < NUM_CH; c++) begin
        if (mask[c] && exp_q[c].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
    if (busy) begin
      note_timeout("packet delivery");
    end
  endtask

  // ----------------------------------------------------------
  // monitor, accepted tx packets in, delivered rx packets out
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (arst_n) begin
      for (int c = 0; c < NUM_CH; c++) begin
        if (tx_vld[c] && tx_rdy[c]) begin
          exp_q[c].push_back(tx_data[c]);
        end
        if (rx_vld[c] && rx_rdy[c]) begin
          if (exp_q[c].size() == 0) begin
            err_cnt++;
            $display("Error at %0t: packet %h on channel %0d was never sent",
                     $time, rx_data[c], c);
          end else begin
            compare_pkt(rx_data[c], exp_q[c].pop_front(), "packet data");
            compare_ch(ch_t'(rx_data[c][PKT_BITS-1 -: $bits(ch_t)]), ch_t'(c),
                       "packet channel");
          end
        end
      end
      if (quiet) begin
        compare_mask(rx_vld, '0, "rx_vld while stopped");
      end
    end
  end

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic reset_and_handshake();
    int n;
    apply_reset();
    // packets offered, none may be taken before the link is up
    tx_vld <= '1;
    @(posedge clk);
    compare_mask(tx_rdy, '0, "tx_rdy after reset");
    compare_mask(rx_vld, '0, "rx_vld after reset");
    compare_bit(handshake_complete, 1'b0, "handshake_complete after reset");
    compare_bit(version_mismatch, 1'b0, "version_mismatch after reset");
    tx_vld <= '0;
    n = 0;
    while (!handshake_complete && n < 100) begin
      @(posedge clk);
      n++;
      if (!handshake_complete) begin
        compare_word({link_tx_data, link_tx_k},
                     {link_id, LINK_VERSION, K_HSHK, 4'b0001}, "handshake word");
      end
    end
    if (!handshake_complete) begin
      note_timeout("handshake_complete");
    end
    compare_id(peer_id, link_id, "peer_id");
    compare_bit(version_mismatch, 1'b0, "version_mismatch after handshake");
    // link up, nothing queued
    @(posedge clk);
    compare_word({link_tx_data, link_tx_k}, {24'h000000, K_COMMA, 4'b0001}, "idle word");
  endtask

  task automatic single_packet_per_channel();
    bit done;
    for (int c = 0; c < NUM_CH; c++) begin
      load_quota(c == 0, c == 1, c == 2, c == 3);
      stream(100, done);
      if (!done) begin
        note_timeout("single packet accept");
      end
      wait_drain('1, 200);
    end
  endtask

  task automatic all_channels_at_once();
    bit done;
    load_quota(12, 12, 12, 12);
    stream(2000, done);
    if (!done) begin
      note_timeout("all-channel accept");
    end
    wait_drain('1, 500);
  endtask

  task automatic back_pressure();
    bit done;
    rx_rdy[2] <= 1'b0;
    load_quota(3, 3, 6, 3);
    // channel 2 stalls once its credits are gone
    stream(300, done);
    compare_credit(credit_t'(sent[2]), credit_t'(FIFO_DEPTH), "channel 2 accepts while held");
    compare_bit(tx_rdy[2], 1'b0, "channel 2 tx_rdy while held");
    wait_drain(4'b1011, 300);
    rx_rdy[2] <= 1'b1;
    stream(300, done);
    if (!done) begin
      note_timeout("channel 2 accept after release");
    end
    wait_drain('1, 300);
  endtask

  task automatic stop_and_resume();
    bit done;
    stop  <= 1'b1;
    quiet <= 1'b1;
    load_quota(2, 2, 2, 2);
    stream(40, done);
    stop  <= 1'b0;
    quiet <= 1'b0;
    stream(300, done);
    if (!done) begin
      note_timeout("accept after stop");
    end
    wait_drain('1, 300);
  endtask

  task automatic wrong_version();
    int n;
    inject   <= 1'b1;
    inj_data <= {link_id, LINK_VERSION + 8'h01, K_HSHK};
    inj_k    <= 4'b0001;
    apply_reset();
    n = 0;
    while (!version_mismatch && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (!version_mismatch) begin
      note_timeout("version_mismatch");
    end
    // link must stay down
    repeat (20) begin
      @(posedge clk);
      compare_bit(handshake_complete, 1'b0, "handshake_complete with wrong version");
    end
  endtask

  initial begin
    err_cnt  = 0;
    chk_cnt  = 0;
    quiet    <= 1'b0;
    link_id  <= 16'h5a3c;
    inject   <= 1'b0;
    inj_data <= '0;
    inj_k    <= '0;
    for (int c = 0; c < NUM_CH; c++) begin
      tx_data[c] <= '0;
    end
    reset_and_handshake();
    single_packet_per_channel();
    all_channels_at_once();
    back_pressure();
    stop_and_resume();
    wrong_version();
    $display("errors: %0d, checks: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: hssl_interface.sv
// ----------------------------------------------------------
// four-channel serial link packet multiplexer, top level
//   frame assembler and tx control on the transmit side
//   rx control and frame disassembler on the receive side
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_interface (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [15:0]                       link_id,
  input  logic                              stop,

  // transmit channels
  input  hssl_pkt_pkg::pkt_t                tx_data [hssl_pkt_pkg::NUM_CH],
  input  logic [hssl_pkt_pkg::NUM_CH-1:0]   tx_vld,
  output logic [hssl_pkt_pkg::NUM_CH-1:0]   tx_rdy,

  // receive channels
  output hssl_pkt_pkg::pkt_t                rx_data [hssl_pkt_pkg::NUM_CH],
  output logic [hssl_pkt_pkg::NUM_CH-1:0]   rx_vld,
  input  logic [hssl_pkt_pkg::NUM_CH-1:0]   rx_rdy,

  // link status
  output logic                              handshake_complete,
  output logic                              version_mismatch,
  output logic [15:0]                       peer_id,

  // transceiver user data
  output logic [31:0]                       link_tx_data,
  output logic [3:0]                        link_tx_k,
  input  logic [31:0]                       link_rx_data,
  input  logic [3:0]                        link_rx_k
);

  import hssl_pkt_pkg::*;

  // assembler to tx control
  logic [31:0]       frm_data;
  logic [3:0]        frm_k;
  logic              frm_vld;
  logic              frm_rdy;

  // rx control to disassembler
  logic [31:0]       rx_word_data;
  logic [3:0]        rx_word_k;
  logic              rx_word_vld;

  // credit events, receive side back to transmit side
  logic [NUM_CH-1:0] credit_in;
  logic [NUM_CH-1:0] credit_ret;

  // ----------------------------------------------------------
  // transmit path
  // ----------------------------------------------------------
  hssl_frame_assembler assembler_i (
      .clk        (clk)
    , .arst_n     (arst_n)
    , .tx_data    (tx_data)
    , .tx_vld     (tx_vld)
    , .tx_rdy     (tx_rdy)
    , .credit_in  (credit_in)
    , .credit_ret (credit_ret)
    , .frm_data   (frm_data)
    , .frm_k      (frm_k)
    , .frm_vld    (frm_vld)
    , .frm_rdy    (frm_rdy)
  );

  hssl_tx_control tx_control_i (
      .clk                (clk)
    , .arst_n             (arst_n)
    , .link_id            (link_id)
    , .stop               (stop)
    , .handshake_complete (handshake_complete)
    , .frm_data           (frm_data)
    , .frm_k              (frm_k)
    , .frm_vld            (frm_vld)
    , .frm_rdy            (frm_rdy)
    , .link_tx_data       (link_tx_data)
    , .link_tx_k          (link_tx_k)
  );

  // ----------------------------------------------------------
  // receive path
  // ----------------------------------------------------------
  hssl_rx_control rx_control_i (
      .clk                (clk)
    , .arst_n             (arst_n)
    , .link_rx_data       (link_rx_data)
    , .link_rx_k          (link_rx_k)
    , .handshake_complete (handshake_complete)
    , .version_mismatch   (version_mismatch)
    , .peer_id            (peer_id)
    , .rx_word_data       (rx_word_data)
    , .rx_word_k          (rx_word_k)
    , .rx_word_vld        (rx_word_vld)
  );

  hssl_frame_disassembler disassembler_i (
      .clk          (clk)
    , .arst_n       (arst_n)
    , .rx_word_data (rx_word_data)
    , .rx_word_k    (rx_word_k)
    , .rx_word_vld  (rx_word_vld)
    , .rx_data      (rx_data)
    , .rx_vld       (rx_vld)
    , .rx_rdy       (rx_rdy)
    , .credit_in    (credit_in)
    , .credit_ret   (credit_ret)
  );

endmodule

// File: hssl_rx_control.sv
// ----------------------------------------------------------
// receive link control
//   handshake word counter and version check
//   peer link id capture
//   forwarding of frame words once the link is up
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_rx_control (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] link_rx_data,
  input  logic [3:0]  link_rx_k,
  output logic        handshake_complete,
  output logic        version_mismatch,
  output logic [15:0] peer_id,
  output logic [31:0] rx_word_data,
  output logic [3:0]  rx_word_k,
  output logic        rx_word_vld
);

  import hssl_link_pkg::*;

  logic                          is_hshk;
  logic                          is_idle;
  logic                          ver_ok;
  // good handshake words seen in a row
  logic [$clog2(HSHK_COUNT)-1:0] hshk_cnt_q;

  assign is_hshk = (link_rx_k == 4'b0001) && (link_rx_data[7:0] == K_HSHK);
  assign is_idle = (link_rx_k == 4'b0001) && (link_rx_data[7:0] == K_COMMA);
  assign ver_ok  = (link_rx_data[15:8] == LINK_VERSION);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hshk_cnt_q         <= '0;
      handshake_complete <= 1'b0;
      version_mismatch   <= 1'b0;
      peer_id            <= '0;
      rx_word_vld        <= 1'b0;
    end else begin
      if (!handshake_complete) begin
        if (is_hshk && ver_ok) begin
          // last one of the run brings the link up
          if (hshk_cnt_q == HSHK_COUNT-1) begin
            handshake_complete <= 1'b1;
          end
          hshk_cnt_q <= hshk_cnt_q + 1'b1;
          peer_id    <= link_rx_data[31:16];
        end else begin
          hshk_cnt_q <= '0;
        end
      end
      // sticky until reset
      if (is_hshk && !ver_ok) begin
        version_mismatch <= 1'b1;
      end
      // peer may still be handshaking, those words are dropped
      rx_word_vld <= handshake_complete && !is_hshk && !is_idle;
    end
  end

  always_ff @(posedge clk) begin
    rx_word_data <= link_rx_data;
    rx_word_k    <= link_rx_k;
  end

  // the far transmitter only ever sends K-characters in byte 0
  a_k_byte0: assert property (@(posedge clk) disable iff (!arst_n) link_rx_k[3:1] == 3'b000);

endmodule

// File: hssl_tx_control.sv
// ----------------------------------------------------------
// transmit link control
//   handshake words until the link is up, idles otherwise
//   two-word skid buffer behind a registered frm_rdy
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_tx_control (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] link_id,
  input  logic        stop,
  input  logic        handshake_complete,
  input  logic [31:0] frm_data,
  input  logic [3:0]  frm_k,
  input  logic        frm_vld,
  output logic        frm_rdy,
  output logic [31:0] link_tx_data,
  output logic [3:0]  link_tx_k
);

  import hssl_link_pkg::*;

  link_word_t frm_word;
  link_word_t skid_word;
  logic       accept;
  logic       send_ok;
  logic       skid_rd;
  logic       skid_wr;
  logic       bypass;
  logic       skid_empty;
  logic       skid_full;

  assign frm_word = '{data: frm_data, k: frm_k};
  assign accept   = frm_vld && frm_rdy;

  // frame words go out only after the handshake and outside stop
  assign send_ok = handshake_complete && !stop;
  // older buffered word first, else straight through
  assign skid_rd = send_ok && !skid_empty;
  assign bypass  = send_ok && skid_empty && accept;
  assign skid_wr = accept && !bypass;

  // catches the word accepted in the cycle stop rises
  hssl_pkt_fifo #(
      .item_t (link_word_t)
    , .DEPTH  (2)
  ) skid_i (
      .clk     (clk)
    , .arst_n  (arst_n)
    , .wr_data (frm_word)
    , .wr_en   (skid_wr)
    , .full    (skid_full)
    , .rd_data (skid_word)
    , .rd_en   (skid_rd)
    , .empty   (skid_empty)
  );

  // ----------------------------------------------------------
  // output word select, one word every cycle
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      frm_rdy      <= 1'b0;
      link_tx_data <= {24'h000000, K_COMMA};
      link_tx_k    <= 4'b0001;
    end else begin
      frm_rdy <= send_ok && !skid_full;
      if (!handshake_complete) begin
        link_tx_data <= {link_id, LINK_VERSION, K_HSHK};
        link_tx_k    <= 4'b0001;
      end else if (skid_rd) begin
        link_tx_data <= skid_word.data;
        link_tx_k    <= skid_word.k;
      end else if (bypass) begin
        link_tx_data <= frm_data;
        link_tx_k    <= frm_k;
      end else begin
        // nothing waiting
        link_tx_data <= {24'h000000, K_COMMA};
        link_tx_k    <= 4'b0001;
      end
    end
  end

endmodule

// File: hssl_frame_disassembler.sv
// ----------------------------------------------------------
// receive frame disassembler
//   header decoder for data and credit frames
//   one receive FIFO per channel
//   credit_in on credit frames, credit_ret on FIFO reads
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_frame_disassembler (
  input  logic                              clk,
  input  logic                              arst_n,

  // frame words from rx control
  input  logic [31:0]                       rx_word_data,
  input  logic [3:0]                        rx_word_k,
  input  logic                              rx_word_vld,

  // channel packets out
  output hssl_pkt_pkg::pkt_t                rx_data [hssl_pkt_pkg::NUM_CH],
  output logic [hssl_pkt_pkg::NUM_CH-1:0]   rx_vld,
  input  logic [hssl_pkt_pkg::NUM_CH-1:0]   rx_rdy,

  // credit events toward the assembler
  output logic [hssl_pkt_pkg::NUM_CH-1:0]   credit_in,
  output logic [hssl_pkt_pkg::NUM_CH-1:0]   credit_ret
);

  import hssl_link_pkg::*;
  import hssl_pkt_pkg::*;

  // waiting for a header, or for the packet word
  typedef enum logic {S_HDR, S_PKT} state_t;

  state_t            state_q;
  ch_t               ch_q;
  pkt_t              wr_data_q;
  logic [NUM_CH-1:0] wr_en_q;
  logic [NUM_CH-1:0] empty;
  logic [NUM_CH-1:0] rd_en;
  logic              is_hdr;
  ch_t               hdr_ch;

  assign is_hdr = rx_word_vld && (rx_word_k == 4'b0001) && (rx_word_data[7:0] == K_SOF);
  assign hdr_ch = ch_t'(rx_word_data[15:8]);

  // ----------------------------------------------------------
  // header decode
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= S_HDR;
      ch_q      <= '0;
      wr_en_q   <= '0;
      credit_in <= '0;
    end else begin
      // single-cycle strobes
      wr_en_q   <= '0;
      credit_in <= '0;
      case (state_q)
        S_HDR: begin
          if (is_hdr && rx_word_data[23:16] == FRM_DATA) begin
            ch_q    <= hdr_ch;
            state_q <= S_PKT;
          end else if (is_hdr && rx_word_data[23:16] == FRM_CREDIT) begin
            credit_in[hdr_ch] <= 1'b1;
          end
        end
        S_PKT: begin
          // a K word here means a broken frame, dropped
          if (rx_word_vld) begin
            wr_en_q[ch_q] <= (rx_word_k == 4'b0000);
            state_q       <= S_HDR;
          end
        end
        default: state_q <= S_HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_PKT && rx_word_vld) begin
      wr_data_q <= rx_word_data;
    end
  end

  // ----------------------------------------------------------
  // receive FIFOs
  // ----------------------------------------------------------
  assign rx_vld     = ~empty;
  assign rd_en      = rx_vld & rx_rdy;
  // every packet handed out frees one slot at this end
  assign credit_ret = rd_en;

  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    hssl_pkt_fifo #(
        .item_t (pkt_t)
      , .DEPTH  (FIFO_DEPTH)
    ) fifo_i (
        .clk     (clk)
      , .arst_n  (arst_n)
      , .wr_data (wr_data_q)
      , .wr_en   (wr_en_q[g])
      , .full    ()
      , .rd_data (rx_data[g])
      , .rd_en   (rd_en[g])
      , .empty   (empty[g])
    );
  end

endmodule

// File: hssl_frame_assembler.sv
// ----------------------------------------------------------
// transmit frame assembler
//   per-channel credit and pending-return counters
//   round-robin arbiter over channels with packet and credit
//   builds credit frames (first) and two-word data frames
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_frame_assembler (
  input  logic                              clk,
  input  logic                              arst_n,

  // channel packets in
  input  hssl_pkt_pkg::pkt_t                tx_data [hssl_pkt_pkg::NUM_CH],
  input  logic [hssl_pkt_pkg::NUM_CH-1:0]   tx_vld,
  output logic [hssl_pkt_pkg::NUM_CH-1:0]   tx_rdy,

  // credit events from the disassembler
  input  logic [hssl_pkt_pkg::NUM_CH-1:0]   credit_in,
  input  logic [hssl_pkt_pkg::NUM_CH-1:0]   credit_ret,

  // frame words toward tx control
  output logic [31:0]                       frm_data,
  output logic [3:0]                        frm_k,
  output logic                              frm_vld,
  input  logic                              frm_rdy
);

  import hssl_link_pkg::*;
  import hssl_pkt_pkg::*;

  // free or holding the packet word of a data frame
  typedef enum logic {S_FREE, S_DATA} state_t;

  state_t  state_q;
  credit_t credit_q [NUM_CH];
  credit_t pend_q   [NUM_CH];
  // last channel granted a data frame
  ch_t     rr_q;
  pkt_t    pkt_q;

  logic [NUM_CH-1:0] has_pend;
  logic [NUM_CH-1:0] eligible;
  logic [NUM_CH-1:0] send_credit;
  logic [NUM_CH-1:0] take_pkt;
  logic              any_pend;
  logic              any_elig;
  ch_t               pend_ch;
  ch_t               data_ch;

  // ----------------------------------------------------------
  // arbitration
  // ----------------------------------------------------------
  always_comb begin
    ch_t idx;
    for (int i = 0; i < NUM_CH; i++) begin
      has_pend[i] = (pend_q[i] != '0);
      eligible[i] = tx_vld[i] && (credit_q[i] != '0);
    end
    // credit returns, lowest channel first
    pend_ch  = '0;
    any_pend = 1'b0;
    for (int i = NUM_CH-1; i >= 0; i--) begin
      if (has_pend[i]) begin
        pend_ch  = ch_t'(i);
        any_pend = 1'b1;
      end
    end
    // data, round robin starting after rr_q
    // the nearest channel is visited last and wins
    data_ch  = rr_q;
    any_elig = 1'b0;
    for (int i = NUM_CH; i >= 1; i--) begin
      idx = rr_q + ch_t'(i);
      if (eligible[idx]) begin
        data_ch  = idx;
        any_elig = 1'b1;
      end
    end
  end

  // one grant per cycle, credit frame before data
  always_comb begin
    send_credit = '0;
    tx_rdy      = '0;
    if (state_q == S_FREE && frm_rdy) begin
      if (any_pend) begin
        send_credit[pend_ch] = 1'b1;
      end else if (any_elig) begin
        tx_rdy[data_ch] = 1'b1;
      end
    end
  end

  assign take_pkt = tx_rdy & tx_vld;

  // ----------------------------------------------------------
  // frame words
  // ----------------------------------------------------------
  assign frm_vld = (state_q == S_DATA) || any_pend || any_elig;

  always_comb begin
    if (state_q == S_DATA) begin
      frm_data = pkt_q;
      frm_k    = 4'b0000;
    end else if (any_pend) begin
      frm_data = {8'h00, FRM_CREDIT, 8'(pend_ch), K_SOF};
      frm_k    = 4'b0001;
    end else begin
      frm_data = {8'h00, FRM_DATA, 8'(data_ch), K_SOF};
      frm_k    = 4'b0001;
    end
  end

  // ----------------------------------------------------------
  // counters and state
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_FREE;
      rr_q    <= '0;
      for (int i = 0; i < NUM_CH; i++) begin
        credit_q[i] <= credit_t'(FIFO_DEPTH);
        pend_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        // peer freed a slot, or we used one
        credit_q[i] <= credit_q[i] + credit_t'(credit_in[i]) - credit_t'(take_pkt[i]);
        // local slot freed, or its credit frame went out
        pend_q[i]   <= pend_q[i] + credit_t'(credit_ret[i]) - credit_t'(send_credit[i]);
      end
      case (state_q)
        S_FREE: begin
          if (|take_pkt) begin
            state_q <= S_DATA;
            rr_q    <= data_ch;
          end
        end
        S_DATA: begin
          if (frm_rdy) begin
            state_q <= S_FREE;
          end
        end
        default: state_q <= S_FREE;
      endcase
    end
  end

  // packet held for the second word of the data frame
  always_ff @(posedge clk) begin
    if (|take_pkt) begin
      pkt_q <= tx_data[data_ch];
    end
  end

  // the peer never returns more credit than its FIFO holds
  for (genvar g = 0; g < NUM_CH; g++) begin : g_credit_chk
    a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
      credit_q[g] <= credit_t'(FIFO_DEPTH));
  end

endmodule

// File: hssl_pkt_fifo.sv
// ----------------------------------------------------------
// register-based circular FIFO
//   payload type and depth set by parameters
//   combinational read port, head word always visible
// ----------------------------------------------------------

`timescale 1ns/10ps
module hssl_pkt_fifo #(
  parameter type item_t = logic [31:0],
  parameter int  DEPTH  = 4
) (
  input  logic  clk,
  input  logic  arst_n,
  input  item_t wr_data,
  input  logic  wr_en,
  output logic  full,
  output item_t rd_data,
  input  logic  rd_en,
  output logic  empty
);

  // storage
  item_t mem_q [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  // one extra bit so DEPTH fits
  logic [$clog2(DEPTH):0]   count_q;

  assign full    = (count_q == DEPTH);
  assign empty   = (count_q == 0);
  assign rd_data = mem_q[rd_ptr_q];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + wr_en - rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_data;
    end
  end

  // the producer and consumer must respect full and empty
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !(wr_en && full));
  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) !(rd_en && empty));

endmodule

// File: hssl_pkt_pkg.sv
// ----------------------------------------------------------
// packet-layer definitions
//   channel count and channel index type
//   packet type
//   frame kind codes for header byte 2
//   receive FIFO depth and credit counter type
// ----------------------------------------------------------

package hssl_pkt_pkg;

  // number of multiplexed channels
  localparam int NUM_CH   = 4;
  localparam int PKT_BITS = 32;

  typedef logic [PKT_BITS-1:0]       pkt_t;
  typedef logic [$clog2(NUM_CH)-1:0] ch_t;

  // slots per receive FIFO
  // also the credit a transmit channel starts with
  localparam int FIFO_DEPTH = 4;

  // must hold 0..FIFO_DEPTH
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

  // ----------------------------------------------------------
  // frame kinds
  // ----------------------------------------------------------
  // header then one packet word
  localparam logic [7:0] FRM_DATA   = 8'h01;
  // header alone, returns one credit
  localparam logic [7:0] FRM_CREDIT = 8'h02;

endpackage

// File: hssl_link_pkg.sv
// ----------------------------------------------------------
// link-layer definitions for the serial link
//   K-character codes for idle, handshake and frame start
//   protocol version and handshake length
//   link word type, 32-bit data plus per-byte K flags
// ----------------------------------------------------------

package hssl_link_pkg;

  // ----------------------------------------------------------
  // K-character codes, always placed in byte 0
  // ----------------------------------------------------------
  // K28.5, idle comma
  localparam logic [7:0] K_COMMA = 8'hbc;
  // K28.3, handshake marker
  localparam logic [7:0] K_HSHK  = 8'h7c;
  // K27.7, start of frame
  localparam logic [7:0] K_SOF   = 8'hfb;

  // version carried in byte 1 of every handshake word
  localparam logic [7:0] LINK_VERSION = 8'h01;

  // consecutive good handshake words before the link is up
  localparam int HSHK_COUNT = 4;

  // one transceiver word, k[i] flags byte i as a K-character
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  k;
  } link_word_t;

endpackage
